// ==== hw/cause_tracker.sv ====
// Tracks what the core must report on its next debug entry.
// Keeps the expected dcsr cause, the predicted dpc and the WFI sleep state,
// all updated one cycle after the decoder stage.
// Cause and dpc only move on retirements outside debug mode.

`timescale 1ns/1ps

module cause_tracker #(
  parameter int unsigned PC_W = 32
) (
  input  logic                            cov_assert_if,
  input  logic                            reset_i,
  input  logic                            st_valid_i,
  input  logic [PC_W-1:0]                 st_pc_i,
  input  logic [PC_W-1:0]                 st_next_pc_i,
  input  logic                            st_debug_mode_i,
  input  logic                            st_debug_req_i,
  input  logic                            st_step_i,
  input  logic                            st_ebreakm_i,
  input  logic                            st_trigger_i,
  input  logic                            st_irq_i,
  input  logic                            dec_ebreak_i,
  input  logic                            dec_wfi_i,
  output logic [dbg_mon_pkg::CAUSE_W-1:0] cause_o,
  output logic [PC_W-1:0]                 dpc_pred_o,
  output logic                            in_wfi_o
);

  import dbg_mon_pkg::*;

  logic [CAUSE_W-1:0] cause_q;
  logic [CAUSE_W-1:0] cause_d;
  logic [PC_W-1:0]    dpc_q;
  logic [PC_W-1:0]    dpc_d;
  logic               in_wfi_q;
  logic               track_en;
  logic               wfi_set;
  logic               wfi_clr;

  // Only retirements in normal mode change the prediction
  assign track_en = st_valid_i && !st_debug_mode_i;

  // ----------------------------------------
  // Cause priority
  // ----------------------------------------

  // Trigger beats ebreak beats haltreq beats step
  always_comb begin
    if (st_trigger_i) begin
      cause_d = CAUSE_TRIGGER;
    end else if (dec_ebreak_i && st_ebreakm_i) begin
      cause_d = CAUSE_EBREAK;
    end else if (st_debug_req_i) begin
      cause_d = CAUSE_HALTREQ;
    end else if (st_step_i && ((cause_q == CAUSE_NONE) || (cause_q == CAUSE_STEP))) begin
      cause_d = CAUSE_STEP;
    end else begin
      cause_d = CAUSE_NONE;
    end
  end

  // Trigger and ebreak halt before the instruction completes, so dpc points at it
  always_comb begin
    if ((cause_d == CAUSE_TRIGGER) || (cause_d == CAUSE_EBREAK)) begin
      dpc_d = st_pc_i;
    end else begin
      dpc_d = st_next_pc_i;
    end
  end

  always_ff @(posedge cov_assert_if) begin
    if (reset_i) begin
      cause_q <= CAUSE_NONE;
      dpc_q   <= '0;
    end else if (track_en) begin
      cause_q <= cause_d;
      dpc_q   <= dpc_d;
    end
  end

  // ----------------------------------------
  // WFI sleep state
  // ----------------------------------------

  // No sleep in debug mode, while stepping or with a halt request pending
  assign wfi_set = dec_wfi_i && !st_debug_mode_i && !st_step_i && !st_debug_req_i;
  assign wfi_clr = st_irq_i || st_debug_req_i;

  // Wake-up has priority over a new wfi
  always_ff @(posedge cov_assert_if) begin
    if (reset_i) begin
      in_wfi_q <= 1'b0;
    end else if (wfi_clr) begin
      in_wfi_q <= 1'b0;
    end else if (wfi_set) begin
      in_wfi_q <= 1'b1;
    end
  end

  assign cause_o    = cause_q;
  assign dpc_pred_o = dpc_q;
  assign in_wfi_o   = in_wfi_q;

endmodule

// ==== hw/dbg_entry_monitor.sv ====
// Debug-entry monitor for a small RISC-V core.
// Feed it the retirement stream and debug status; it predicts cause, dpc and
// WFI state and flags bad debug entries. Outputs lag the inputs by two cycles.

`timescale 1ns/1ps

module dbg_entry_monitor #(
  parameter int unsigned PC_W = 32
) (
  input  logic                            cov_assert_if,
  input  logic                            reset_i,
  input  logic                            retire_valid_i,
  input  logic [PC_W-1:0]                 retire_pc_i,
  input  logic [PC_W-1:0]                 retire_next_pc_i,
  input  logic [31:0]                     retire_instr_i,
  input  logic                            debug_mode_i,
  input  logic                            debug_req_i,
  input  logic                            dcsr_step_i,
  input  logic                            dcsr_ebreakm_i,
  input  logic                            trigger_hit_i,
  input  logic                            irq_pending_i,
  input  logic [PC_W-1:0]                 halt_addr_i,
  output logic [dbg_mon_pkg::CAUSE_W-1:0] cause_o,
  output logic [PC_W-1:0]                 dpc_pred_o,
  output logic                            in_wfi_o,
  output logic                            first_dbg_o,
  output logic                            halt_pc_err_o,
  output logic                            dret_mmode_o
);

  // Staged retirement, shared by both second-stage blocks
  logic            st_valid;
  logic [PC_W-1:0] st_pc;
  logic [PC_W-1:0] st_next_pc;
  logic            st_debug_mode;
  logic            st_debug_req;
  logic            st_step;
  logic            st_ebreakm;
  logic            st_trigger;
  logic            st_irq;
  logic [PC_W-1:0] st_halt_addr;
  logic            dec_ebreak;
  logic            dec_wfi;
  logic            dec_dret;

  retire_decoder #(
    .PC_W (PC_W)
  ) i_retire_decoder (
    .cov_assert_if    (cov_assert_if),
    .reset_i          (reset_i),
    .retire_valid_i   (retire_valid_i),
    .retire_pc_i      (retire_pc_i),
    .retire_next_pc_i (retire_next_pc_i),
    .retire_instr_i   (retire_instr_i),
    .debug_mode_i     (debug_mode_i),
    .debug_req_i      (debug_req_i),
    .dcsr_step_i      (dcsr_step_i),
    .dcsr_ebreakm_i   (dcsr_ebreakm_i),
    .trigger_hit_i    (trigger_hit_i),
    .irq_pending_i    (irq_pending_i),
    .halt_addr_i      (halt_addr_i),
    .st_valid_o       (st_valid),
    .st_pc_o          (st_pc),
    .st_next_pc_o     (st_next_pc),
    .st_debug_mode_o  (st_debug_mode),
    .st_debug_req_o   (st_debug_req),
    .st_step_o        (st_step),
    .st_ebreakm_o     (st_ebreakm),
    .st_trigger_o     (st_trigger),
    .st_irq_o         (st_irq),
    .st_halt_addr_o   (st_halt_addr),
    .dec_ebreak_o     (dec_ebreak),
    .dec_wfi_o        (dec_wfi),
    .dec_dret_o       (dec_dret)
  );

  cause_tracker #(
    .PC_W (PC_W)
  ) i_cause_tracker (
    .cov_assert_if   (cov_assert_if),
    .reset_i         (reset_i),
    .st_valid_i      (st_valid),
    .st_pc_i         (st_pc),
    .st_next_pc_i    (st_next_pc),
    .st_debug_mode_i (st_debug_mode),
    .st_debug_req_i  (st_debug_req),
    .st_step_i       (st_step),
    .st_ebreakm_i    (st_ebreakm),
    .st_trigger_i    (st_trigger),
    .st_irq_i        (st_irq),
    .dec_ebreak_i    (dec_ebreak),
    .dec_wfi_i       (dec_wfi),
    .cause_o         (cause_o),
    .dpc_pred_o      (dpc_pred_o),
    .in_wfi_o        (in_wfi_o)
  );

  debug_entry_check #(
    .PC_W (PC_W)
  ) i_debug_entry_check (
    .cov_assert_if   (cov_assert_if),
    .reset_i         (reset_i),
    .st_valid_i      (st_valid),
    .st_pc_i         (st_pc),
    .st_debug_mode_i (st_debug_mode),
    .st_halt_addr_i  (st_halt_addr),
    .dec_ebreak_i    (dec_ebreak),
    .dec_dret_i      (dec_dret),
    .first_dbg_o     (first_dbg_o),
    .halt_pc_err_o   (halt_pc_err_o),
    .dret_mmode_o    (dret_mmode_o)
  );

endmodule

// ==== hw/dbg_mon_pkg.sv ====
// Shared constants and types for the debug-entry monitor.
// Holds the instruction encodings the decoder looks for, the dcsr cause codes
// and the view of a retired instruction word as full or as two halves.

package dbg_mon_pkg;

  // ----------------------------------------
  // Instruction encodings
  // ----------------------------------------

  // Full 32-bit system instructions
  localparam logic [31:0] EBREAK_OPCODE = 32'h0010_0073;
  localparam logic [31:0] WFI_OPCODE    = 32'h1050_0073;
  localparam logic [31:0] DRET_OPCODE   = 32'h7b20_0073;

  // Compressed ebreak, found in the low half of the word
  localparam logic [15:0] CEBREAK_OPCODE = 16'h9002;

  // ----------------------------------------
  // Debug cause codes
  // ----------------------------------------

  // Same encoding as dcsr.cause
  localparam int unsigned CAUSE_W = 3;

  localparam logic [CAUSE_W-1:0] CAUSE_NONE    = 3'd0;
  localparam logic [CAUSE_W-1:0] CAUSE_EBREAK  = 3'd1;
  localparam logic [CAUSE_W-1:0] CAUSE_TRIGGER = 3'd2;
  localparam logic [CAUSE_W-1:0] CAUSE_HALTREQ = 3'd3;
  localparam logic [CAUSE_W-1:0] CAUSE_STEP    = 3'd4;

  // ----------------------------------------
  // Instruction word
  // ----------------------------------------

  // One retired word, read two ways
  //   word    : the whole 32-bit instruction
  //   half[1] : upper 16 bits
  //   half[0] : lower 16 bits, where a compressed instruction sits
  // A compressed instruction has half[0][1:0] != 2'b11
  typedef union packed {
    logic [31:0]       word;
    logic [1:0][15:0]  half;
  } instr_word_u;

endpackage

// ==== hw/debug_entry_check.sv ====
// Output stage of the debug-entry monitor.
// Spots the first instruction retired in debug mode, checks it against the
// aligned halt address and flags a dret retired in machine mode.
// All three outputs are registered one-cycle pulses.

`timescale 1ns/1ps

module debug_entry_check #(
  parameter int unsigned PC_W = 32
) (
  input  logic            cov_assert_if,
  input  logic            reset_i,
  input  logic            st_valid_i,
  input  logic [PC_W-1:0] st_pc_i,
  input  logic            st_debug_mode_i,
  input  logic [PC_W-1:0] st_halt_addr_i,
  input  logic            dec_ebreak_i,
  input  logic            dec_dret_i,
  output logic            first_dbg_o,
  output logic            halt_pc_err_o,
  output logic            dret_mmode_o
);

  logic            seen_q;
  logic            first_hit;
  logic [PC_W-1:0] halt_aligned;
  logic            first_dbg_q;
  logic            halt_pc_err_q;
  logic            dret_mmode_q;

  // ----------------------------------------
  // First instruction in debug mode
  // ----------------------------------------

  assign first_hit = st_valid_i && st_debug_mode_i && !seen_q;

  // Set once debug code starts retiring
  // An ebreak inside debug mode jumps back to the halt address, so rearm
  always_ff @(posedge cov_assert_if) begin
    if (reset_i) begin
      seen_q <= 1'b0;
    end else if (!st_debug_mode_i) begin
      seen_q <= 1'b0;
    end else if (dec_ebreak_i) begin
      seen_q <= 1'b0;
    end else if (st_valid_i) begin
      seen_q <= 1'b1;
    end
  end

  // Halt address is word aligned by the core
  assign halt_aligned = {st_halt_addr_i[PC_W-1:2], 2'b00};

  // ----------------------------------------
  // Event and fault pulses
  // ----------------------------------------

  always_ff @(posedge cov_assert_if) begin
    if (reset_i) begin
      first_dbg_q   <= 1'b0;
      halt_pc_err_q <= 1'b0;
      dret_mmode_q  <= 1'b0;
    end else begin
      first_dbg_q   <= first_hit;
      halt_pc_err_q <= first_hit && (st_pc_i != halt_aligned);
      // dret is illegal outside debug mode
      dret_mmode_q  <= dec_dret_i && !st_debug_mode_i;
    end
  end

  assign first_dbg_o   = first_dbg_q;
  assign halt_pc_err_o = halt_pc_err_q;
  assign dret_mmode_o  = dret_mmode_q;

endmodule

// ==== hw/retire_decoder.sv ====
// Input stage of the debug-entry monitor.
// Captures every retirement together with the core status in one register
// stage and classifies the staged word as ebreak, wfi or dret.

`timescale 1ns/1ps

module retire_decoder #(
  parameter int unsigned PC_W = 32
) (
  input  logic            cov_assert_if,
  input  logic            reset_i,
  input  logic            retire_valid_i,
  input  logic [PC_W-1:0] retire_pc_i,
  input  logic [PC_W-1:0] retire_next_pc_i,
  input  logic [31:0]     retire_instr_i,
  input  logic            debug_mode_i,
  input  logic            debug_req_i,
  input  logic            dcsr_step_i,
  input  logic            dcsr_ebreakm_i,
  input  logic            trigger_hit_i,
  input  logic            irq_pending_i,
  input  logic [PC_W-1:0] halt_addr_i,
  output logic            st_valid_o,
  output logic [PC_W-1:0] st_pc_o,
  output logic [PC_W-1:0] st_next_pc_o,
  output logic            st_debug_mode_o,
  output logic            st_debug_req_o,
  output logic            st_step_o,
  output logic            st_ebreakm_o,
  output logic            st_trigger_o,
  output logic            st_irq_o,
  output logic [PC_W-1:0] st_halt_addr_o,
  output logic            dec_ebreak_o,
  output logic            dec_wfi_o,
  output logic            dec_dret_o
);

  import dbg_mon_pkg::*;

  instr_word_u st_instr_q;
  logic        is_compressed;

  // Staged status flags
  always_ff @(posedge cov_assert_if) begin
    if (reset_i) begin
      st_valid_o      <= 1'b0;
      st_debug_mode_o <= 1'b0;
      st_debug_req_o  <= 1'b0;
      st_step_o       <= 1'b0;
      st_ebreakm_o    <= 1'b0;
      st_trigger_o    <= 1'b0;
      st_irq_o        <= 1'b0;
    end else begin
      st_valid_o      <= retire_valid_i;
      st_debug_mode_o <= debug_mode_i;
      st_debug_req_o  <= debug_req_i;
      st_step_o       <= dcsr_step_i;
      st_ebreakm_o    <= dcsr_ebreakm_i;
      st_trigger_o    <= trigger_hit_i;
      st_irq_o        <= irq_pending_i;
    end
  end

  // Staged retirement payload
  always_ff @(posedge cov_assert_if) begin
    st_pc_o         <= retire_pc_i;
    st_next_pc_o    <= retire_next_pc_i;
    st_halt_addr_o  <= halt_addr_i;
    st_instr_q.word <= retire_instr_i;
  end

  // ----------------------------------------
  // Decode of the staged word
  // ----------------------------------------

  // Low two bits of 2'b11 mark a full-width instruction
  assign is_compressed = (st_instr_q.half[0][1:0] != 2'b11);

  assign dec_ebreak_o = st_valid_o
                      && ((st_instr_q.word == EBREAK_OPCODE)
                          || (is_compressed && (st_instr_q.half[0] == CEBREAK_OPCODE)));
  assign dec_wfi_o    = st_valid_o && (st_instr_q.word == WFI_OPCODE);
  assign dec_dret_o   = st_valid_o && (st_instr_q.word == DRET_OPCODE);

endmodule

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the debug-entry monitor testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
  --top-module tb_dbg_entry_monitor -f sim.f
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

out=$(./obj_dir/Vtb_dbg_entry_monitor +verilator+error+limit+100 2>&1)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if echo "$out" | grep -qx "all tests passed"; then
  exit 0
fi
echo "Pass message not found"
exit 1

// ==== sim.f ====
hw/dbg_mon_pkg.sv
hw/retire_decoder.sv
hw/cause_tracker.sv
hw/debug_entry_check.sv
hw/dbg_entry_monitor.sv
verification/dbg_mon_sva.sv
verification/dbg_mon_checker.sv
verification/tb_dbg_entry_monitor.sv

// ==== verification/dbg_mon_checker.sv ====
// Reference model and scoreboard for the debug-entry monitor.
// Samples the DUT inputs on the falling edge, predicts the outputs and
// compares them with the DUT outputs two cycles later.

`timescale 1ns/1ps

module dbg_mon_checker #(
  parameter int unsigned PC_W = 32
) (
  input  logic                            cov_assert_if,
  input  logic                            reset_i,
  input  logic                            retire_valid_i,
  input  logic [PC_W-1:0]                 retire_pc_i,
  input  logic [PC_W-1:0]                 retire_next_pc_i,
  input  logic [31:0]                     retire_instr_i,
  input  logic                            debug_mode_i,
  input  logic                            debug_req_i,
  input  logic                            dcsr_step_i,
  input  logic                            dcsr_ebreakm_i,
  input  logic                            trigger_hit_i,
  input  logic                            irq_pending_i,
  input  logic [PC_W-1:0]                 halt_addr_i,
  input  logic [dbg_mon_pkg::CAUSE_W-1:0] dut_cause_i,
  input  logic [PC_W-1:0]                 dut_dpc_pred_i,
  input  logic                            dut_in_wfi_i,
  input  logic                            dut_first_dbg_i,
  input  logic                            dut_halt_pc_err_i,
  input  logic                            dut_dret_mmode_i,
  output int                              err_cnt_o,
  output int                              check_cnt_o
);

  import dbg_mon_pkg::*;

  // Encodings from the RISC-V spec
  localparam logic [31:0] OP_EBREAK  = 32'h0010_0073;
  localparam logic [31:0] OP_WFI     = 32'h1050_0073;
  localparam logic [31:0] OP_DRET    = 32'h7b20_0073;
  localparam logic [15:0] OP_CEBREAK = 16'h9002;

  // Expected set: cause, dpc, wfi, first, halt error, dret
  localparam int EXP_W = CAUSE_W + PC_W + 4;

  logic [CAUSE_W-1:0] m_cause;
  logic [PC_W-1:0]    m_dpc;
  logic               m_wfi;
  logic               m_seen;
  logic [EXP_W:0]     nxt;
  logic [EXP_W-1:0]   exp_q[$];
  int                 err_cnt = 0;
  int                 check_cnt = 0;

  // Next model state and expected outputs; bit 0 is the armed flag
  function automatic logic [EXP_W:0] predict_outputs();
    logic               is_ebk;
    logic               is_wfi;
    logic               is_dret;
    logic [CAUSE_W-1:0] cause;
    logic [PC_W-1:0]    dpc;
    logic               wfi;
    logic               first;
    logic               seen;
    logic [PC_W-1:0]    halt_al;
    is_ebk  = retire_valid_i && ((retire_instr_i == OP_EBREAK)
              || ((retire_instr_i[1:0] != 2'b11) && (retire_instr_i[15:0] == OP_CEBREAK)));
    is_wfi  = retire_valid_i && (retire_instr_i == OP_WFI);
    is_dret = retire_valid_i && (retire_instr_i == OP_DRET);
    cause   = m_cause;
    dpc     = m_dpc;
    if (retire_valid_i && !debug_mode_i) begin
      cause = trigger_hit_i                ? CAUSE_TRIGGER :
              (is_ebk && dcsr_ebreakm_i)   ? CAUSE_EBREAK  :
              debug_req_i                  ? CAUSE_HALTREQ :
              (dcsr_step_i && ((m_cause == CAUSE_NONE) || (m_cause == CAUSE_STEP)))
                                           ? CAUSE_STEP    : CAUSE_NONE;
      dpc = ((cause == CAUSE_TRIGGER) || (cause == CAUSE_EBREAK)) ? retire_pc_i
                                                                  : retire_next_pc_i;
    end
    if (irq_pending_i || debug_req_i) begin
      wfi = 1'b0;
    end else if (is_wfi && !debug_mode_i && !dcsr_step_i) begin
      wfi = 1'b1;
    end else begin
      wfi = m_wfi;
    end
    first   = retire_valid_i && debug_mode_i && !m_seen;
    halt_al = {halt_addr_i[PC_W-1:2], 2'b00};
    // Leaving debug mode or an ebreak in debug code rearms the detector
    seen    = (!debug_mode_i || is_ebk) ? 1'b0 : (m_seen || retire_valid_i);
    if (reset_i) begin
      return '0;
    end
    return {cause, dpc, wfi, first, first && (retire_pc_i != halt_al),
            is_dret && !debug_mode_i, seen};
  endfunction

  task automatic check_field(input string name, input logic [PC_W-1:0] exp_v,
                             input logic [PC_W-1:0] act_v);
    if (exp_v !== act_v) begin
      err_cnt++;
      $display("** Error %s: expected 0x%0h, got 0x%0h at %0t", name, exp_v, act_v, $time);
    end
  endtask

  task automatic compare_outputs(input logic [EXP_W-1:0] exp_v);
    logic [CAUSE_W-1:0] e_cause;
    logic [PC_W-1:0]    e_dpc;
    logic               e_wfi;
    logic               e_first;
    logic               e_herr;
    logic               e_dret;
    {e_cause, e_dpc, e_wfi, e_first, e_herr, e_dret} = exp_v;
    check_cnt++;
    check_field("cause_o", PC_W'(e_cause), PC_W'(dut_cause_i));
    check_field("dpc_pred_o", e_dpc, dut_dpc_pred_i);
    check_field("in_wfi_o", PC_W'(e_wfi), PC_W'(dut_in_wfi_i));
    check_field("first_dbg_o", PC_W'(e_first), PC_W'(dut_first_dbg_i));
    check_field("halt_pc_err_o", PC_W'(e_herr), PC_W'(dut_halt_pc_err_i));
    check_field("dret_mmode_o", PC_W'(e_dret), PC_W'(dut_dret_mmode_i));
  endtask

  // ----------------------------------------
  // Mid-cycle sampling, two entries in flight
  // ----------------------------------------

  always @(negedge cov_assert_if) begin
    nxt = predict_outputs();
    if (exp_q.size() == 2) begin
      compare_outputs(exp_q.pop_front());
    end
    exp_q.push_back(nxt[EXP_W:1]);
    m_cause = nxt[EXP_W -: CAUSE_W];
    m_dpc   = nxt[EXP_W-CAUSE_W -: PC_W];
    m_wfi   = nxt[4];
    m_seen  = nxt[0];
  end

  assign err_cnt_o   = err_cnt;
  assign check_cnt_o = check_cnt;

endmodule

// ==== verification/dbg_mon_sva.sv ====
// Port-level assertions for the debug-entry monitor.
// Bound into dbg_entry_monitor and watches only its reset and outputs.

`timescale 1ns/1ps

module dbg_mon_sva #(
  parameter int unsigned PC_W = 32
) (
  input logic                            cov_assert_if,
  input logic                            reset_i,
  input logic [dbg_mon_pkg::CAUSE_W-1:0] cause_i,
  input logic [PC_W-1:0]                 dpc_pred_i,
  input logic                            in_wfi_i,
  input logic                            first_dbg_i,
  input logic                            halt_pc_err_i,
  input logic                            dret_mmode_i
);

  import dbg_mon_pkg::*;

  int fail_cnt = 0;

  // A halt address fault only exists on a first debug instruction
  a_err_with_first: assert property (@(posedge cov_assert_if) disable iff (reset_i)
    halt_pc_err_i |-> first_dbg_i)
    else begin
      $error("halt_pc_err_o high without first_dbg_o");
      fail_cnt++;
    end

  a_cause_legal: assert property (@(posedge cov_assert_if) disable iff (reset_i)
    cause_i <= CAUSE_STEP)
    else begin
      $error("cause_o holds an undefined code");
      fail_cnt++;
    end

  // Every output is cleared one cycle into reset
  a_reset_clear: assert property (@(posedge cov_assert_if)
    reset_i |=> ((cause_i == '0) && (dpc_pred_i == '0) && !in_wfi_i
                 && !first_dbg_i && !halt_pc_err_i && !dret_mmode_i))
    else begin
      $error("outputs not cleared after reset");
      fail_cnt++;
    end

endmodule

bind dbg_entry_monitor dbg_mon_sva #(
  .PC_W (PC_W)
) i_sva (
  .cov_assert_if (cov_assert_if),
  .reset_i       (reset_i),
  .cause_i       (cause_o),
  .dpc_pred_i    (dpc_pred_o),
  .in_wfi_i      (in_wfi_o),
  .first_dbg_i   (first_dbg_o),
  .halt_pc_err_i (halt_pc_err_o),
  .dret_mmode_i  (dret_mmode_o)
);

// ==== verification/tb_dbg_entry_monitor.sv ====
// Testbench for the debug-entry monitor.
// Runs a directed sequence over the cause, dpc, WFI and debug entry rules,
// then seeded random retirements. The checker compares every cycle.

`timescale 1ns/1ps

module tb_dbg_entry_monitor;

  import dbg_mon_pkg::*;

  localparam int unsigned PC_W = 32;
  localparam int RAND_CYCLES    = 2000;
  localparam int TIMEOUT_CYCLES = 3000;
  localparam logic [31:0] FILLER = 32'h0000_0013;

  logic                  cov_assert_if = 1'b0;
  logic                  reset_i;
  logic                  retire_valid_i;
  logic [PC_W-1:0]       retire_pc_i;
  logic [PC_W-1:0]       retire_next_pc_i;
  logic [31:0]           retire_instr_i;
  logic                  debug_mode_i;
  logic                  debug_req_i;
  logic                  dcsr_step_i;
  logic                  dcsr_ebreakm_i;
  logic                  trigger_hit_i;
  logic                  irq_pending_i;
  logic [PC_W-1:0]       halt_addr_i;
  logic [CAUSE_W-1:0]    cause_o;
  logic [PC_W-1:0]       dpc_pred_o;
  logic                  in_wfi_o;
  logic                  first_dbg_o;
  logic                  halt_pc_err_o;
  logic                  dret_mmode_o;
  int                    checker_errs;
  int                    checks_done;
  int                    total_errs;
  int                    cycle_cnt;
  integer                seed = 43;

  always #10 cov_assert_if = ~cov_assert_if;

  dbg_entry_monitor #(
    .PC_W (PC_W)
  ) i_dut (
    .cov_assert_if (cov_assert_if), .reset_i (reset_i),
    .retire_valid_i (retire_valid_i), .retire_pc_i (retire_pc_i),
    .retire_next_pc_i (retire_next_pc_i), .retire_instr_i (retire_instr_i),
    .debug_mode_i (debug_mode_i), .debug_req_i (debug_req_i),
    .dcsr_step_i (dcsr_step_i), .dcsr_ebreakm_i (dcsr_ebreakm_i),
    .trigger_hit_i (trigger_hit_i), .irq_pending_i (irq_pending_i),
    .halt_addr_i (halt_addr_i), .cause_o (cause_o), .dpc_pred_o (dpc_pred_o),
    .in_wfi_o (in_wfi_o), .first_dbg_o (first_dbg_o),
    .halt_pc_err_o (halt_pc_err_o), .dret_mmode_o (dret_mmode_o)
  );

  dbg_mon_checker #(
    .PC_W (PC_W)
  ) i_checker (
    .cov_assert_if (cov_assert_if), .reset_i (reset_i),
    .retire_valid_i (retire_valid_i), .retire_pc_i (retire_pc_i),
    .retire_next_pc_i (retire_next_pc_i), .retire_instr_i (retire_instr_i),
    .debug_mode_i (debug_mode_i), .debug_req_i (debug_req_i),
    .dcsr_step_i (dcsr_step_i), .dcsr_ebreakm_i (dcsr_ebreakm_i),
    .trigger_hit_i (trigger_hit_i), .irq_pending_i (irq_pending_i),
    .halt_addr_i (halt_addr_i), .dut_cause_i (cause_o), .dut_dpc_pred_i (dpc_pred_o),
    .dut_in_wfi_i (in_wfi_o), .dut_first_dbg_i (first_dbg_o),
    .dut_halt_pc_err_i (halt_pc_err_o), .dut_dret_mmode_i (dret_mmode_o),
    .err_cnt_o (checker_errs), .check_cnt_o (checks_done)
  );

  task automatic next_cycle();
    @(posedge cov_assert_if);
    #2;
  endtask

  // One retirement followed by idle
  task automatic send_retire(input logic [PC_W-1:0] pc, input logic [31:0] instr);
    retire_valid_i   = 1'b1;
    retire_pc_i      = pc;
    retire_next_pc_i = (instr[1:0] == 2'b11) ? pc + 32'd4 : pc + 32'd2;
    retire_instr_i   = instr;
    next_cycle();
    retire_valid_i = 1'b0;
  endtask

  task automatic random_cycle();
    logic [31:0] r;
    logic [31:0] w;
    r = $random(seed);
    w = $random(seed);
    if (r[10:8] == 3'd0) begin
      debug_mode_i = ~debug_mode_i;
    end
    debug_req_i    = (r[13:11] == 3'd0);
    dcsr_step_i    = r[14] & r[15];
    dcsr_ebreakm_i = r[16];
    trigger_hit_i  = (r[19:17] == 3'd0);
    irq_pending_i  = (r[22:20] == 3'd0);
    case (r[26:24])
      3'd0:    retire_instr_i = EBREAK_OPCODE;
      3'd1:    retire_instr_i = {w[31:16], CEBREAK_OPCODE};
      3'd2:    retire_instr_i = WFI_OPCODE;
      3'd3:    retire_instr_i = DRET_OPCODE;
      default: retire_instr_i = w;
    endcase
    retire_valid_i   = r[0] | r[1];
    retire_pc_i      = (r[28:27] == 2'd0) ? 32'h0000_0800 : {16'h0, w[15:2], 2'b00};
    retire_next_pc_i = retire_pc_i + 32'd4;
    next_cycle();
  endtask

  // ----------------------------------------
  // Stimulus
  // ----------------------------------------

  initial begin
    reset_i          = 1'b1;
    retire_valid_i   = 1'b0;
    retire_pc_i      = '0;
    retire_next_pc_i = '0;
    retire_instr_i   = '0;
    debug_mode_i     = 1'b0;
    debug_req_i      = 1'b0;
    dcsr_step_i      = 1'b0;
    dcsr_ebreakm_i   = 1'b0;
    trigger_hit_i    = 1'b0;
    irq_pending_i    = 1'b0;
    halt_addr_i      = 32'h0000_0802;
    repeat (10) @(posedge cov_assert_if);
    #2;
    reset_i = 1'b0;

    // Cause priority by removing the winner each time
    dcsr_ebreakm_i = 1'b1;
    debug_req_i    = 1'b1;
    trigger_hit_i  = 1'b1;
    send_retire(32'h100, EBREAK_OPCODE);
    trigger_hit_i = 1'b0;
    send_retire(32'h104, EBREAK_OPCODE);
    dcsr_ebreakm_i = 1'b0;
    send_retire(32'h108, EBREAK_OPCODE);
    debug_req_i = 1'b0;
    dcsr_step_i = 1'b1;
    send_retire(32'h10c, FILLER);
    send_retire(32'h110, FILLER);
    debug_mode_i  = 1'b1;
    trigger_hit_i = 1'b1;
    send_retire(32'h114, FILLER);
    trigger_hit_i = 1'b0;
    debug_mode_i  = 1'b0;
    dcsr_step_i   = 1'b0;

    // Full and compressed ebreak decode
    dcsr_ebreakm_i = 1'b1;
    send_retire(32'h200, {16'h0000, CEBREAK_OPCODE});
    send_retire(32'h202, FILLER);
    send_retire(32'h204, 32'habcd_9003);
    dcsr_ebreakm_i = 1'b0;
    send_retire(32'h208, EBREAK_OPCODE);
    send_retire(32'h20c, {16'h1234, CEBREAK_OPCODE});

    // WFI set, wake-up, and wake-up beating a new wfi
    send_retire(32'h300, WFI_OPCODE);
    next_cycle();
    irq_pending_i = 1'b1;
    next_cycle();
    irq_pending_i = 1'b0;
    send_retire(32'h304, WFI_OPCODE);
    irq_pending_i = 1'b1;
    send_retire(32'h308, WFI_OPCODE);
    irq_pending_i = 1'b0;
    send_retire(32'h30c, WFI_OPCODE);
    debug_req_i = 1'b1;
    send_retire(32'h310, WFI_OPCODE);
    debug_req_i = 1'b0;

    // Debug entry, relaunch after ebreak, bad halt PC, dret in both modes
    debug_mode_i = 1'b1;
    send_retire(32'h800, FILLER);
    send_retire(32'h804, FILLER);
    send_retire(32'h808, EBREAK_OPCODE);
    send_retire(32'h800, FILLER);
    send_retire(32'h804, DRET_OPCODE);
    debug_mode_i = 1'b0;
    next_cycle();
    debug_mode_i = 1'b1;
    send_retire(32'h900, FILLER);
    debug_mode_i = 1'b0;
    send_retire(32'h040, DRET_OPCODE);

    repeat (RAND_CYCLES) random_cycle();

    // Drain the two cycles in flight
    retire_valid_i = 1'b0;
    debug_mode_i   = 1'b0;
    repeat (4) next_cycle();

    total_errs = checker_errs + i_dut.i_sva.fail_cnt;
    $display("errors %0d (checker %0d, assertions %0d), comparisons %0d",
             total_errs, checker_errs, i_dut.i_sva.fail_cnt, checks_done);
    if (total_errs == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

  // Run limit above the reset, directed and random cycles together
  initial begin
    cycle_cnt = 0;
    while (cycle_cnt < TIMEOUT_CYCLES) begin
      @(posedge cov_assert_if);
      cycle_cnt = cycle_cnt + 1;
    end
    $display("run timed out after %0d cycles, errors %0d", cycle_cnt,
             checker_errs + i_dut.i_sva.fail_cnt + 1);
    $display("tests failed");
    $finish;
  end

endmodule
